// File: verilog/beebMemPkg.sv
`default_nettype none

package beebMemPkg;

	localparam int addrWidth = 16;
	localparam int dataWidth = 8;
	localparam int frameWidth = 14;
	localparam int rowWidth = 5;
	localparam int romAddrWidth = 14;

	// SHEILA device selects, active high
	typedef logic [8:0] devSel;

	localparam int selCrtc = 0;
	localparam int selAcia = 1;
	localparam int selVidProc = 2;
	localparam int selRomSel = 3;
	localparam int selVia = 4;
	localparam int selUserVia = 5;
	localparam int selFdc = 6;
	localparam int selAdc = 7;
	localparam int selTube = 8;

	typedef enum logic [1:0] {romNone, romOs, romBasic} romSlot;

	// Screen-size field of the system latch
	localparam int screenSizeLo = 4;
	localparam int screenSizeHi = 5;

	// Added to framestore bits 11:8 once the CRTC runs past the top of RAM
	function automatic logic [3:0] wrapOffset(input logic [1:0] screenSize,
			input logic frameHigh);
		logic [3:0] offset;
		case (screenSize)
			2'd0: offset = 4'd8;
			2'd1: offset = 4'd12;
			2'd2: offset = 4'd6;
			default: offset = 4'd11;
		endcase
		if (!frameHigh) begin
			offset = 4'd0;
		end
		return offset;
	endfunction

endpackage

`default_nettype wire

// File: verilog/procBusIf.sv
`timescale 1ns/1ps
`default_nettype none

interface procBusIf
	import beebMemPkg::*;
();

	// phi2 high is the processor half of the cycle
	logic phi2;
	logic rnw;
	logic [addrWidth-1:0] addr;
	logic [dataWidth-1:0] writeData;

	modport decode (
		input addr,
		input rnw
	);

	modport mem (
		input phi2,
		input rnw,
		input addr,
		input writeData
	);

endinterface

`default_nettype wire

// File: verilog/sheilaDecode.sv
`timescale 1ns/1ps
`default_nettype none

module sheilaDecode
	import beebMemPkg::*;
(
	procBusIf.decode bus,
	output logic sheila,
	output devSel sel
);

	logic [7:0] pageOffset;

	// Page FE
	assign sheila = (&bus.addr[15:9]) & ~bus.addr[8];
	assign pageOffset = bus.addr[7:0];

	// One range compare per device
	assign sel[selCrtc] = sheila && pageOffset[7:3] == 5'b0_0000;
	assign sel[selAcia] = sheila && pageOffset[7:3] == 5'b0_0001;
	// Video ULA and ROM select are write only
	assign sel[selVidProc] = sheila && pageOffset[7:4] == 4'h2 && !bus.rnw;
	assign sel[selRomSel] = sheila && pageOffset[7:4] == 4'h3 && !bus.rnw;
	assign sel[selVia] = sheila && pageOffset[7:5] == 3'b010;
	assign sel[selUserVia] = sheila && pageOffset[7:5] == 3'b011;
	assign sel[selFdc] = sheila && pageOffset[7:5] == 3'b100;
	// FE10-1F and FEA0-BF select nothing
	assign sel[selAdc] = sheila && pageOffset[7:5] == 3'b110;
	assign sel[selTube] = sheila && pageOffset[7:5] == 3'b111;

	// Devices share the data bus, so two selects at once would be a clash
	always_comb begin
		assert ($onehot0(sel))
		else $error("sheilaDecode: more than one select for %h", bus.addr);
	end

endmodule

`default_nettype wire

// File: verilog/systemLatch.sv
`timescale 1ns/1ps
`default_nettype none

module systemLatch (
	input logic CLK_PROC,
	input logic rst,
	input logic latchWrite,
	input logic [2:0] latchIndex,
	input logic latchData,
	output logic [7:0] latchBits
);

	// Addressable latch, one bit per write strobe
	always_ff @(posedge CLK_PROC) begin
		if (rst) begin
			latchBits <= '0;
		end else if (latchWrite) begin
			latchBits[latchIndex] <= latchData;
		end
	end

	// An unknown index would corrupt an arbitrary bit
	assertIndexKnown: assert property (
		@(posedge CLK_PROC) disable iff (rst)
		latchWrite |-> !$isunknown(latchIndex)
	) else $error("systemLatch: write with unknown index");

endmodule

`default_nettype wire

// File: verilog/screenAddrMap.sv
`timescale 1ns/1ps
`default_nettype none

module screenAddrMap
	import beebMemPkg::*;
#(
	parameter int ramAddrWidth = 15
) (
	input logic [frameWidth-1:0] frameStore,
	input logic [rowWidth-1:0] rowAddr,
	input logic [dataWidth-1:0] latchBits,
	output logic [ramAddrWidth-1:0] videoAddr
);

	logic [3:0] wrappedHigh;
	logic [14:0] fullAddr;

	// Sum wraps modulo 16, folding the screen back into its RAM window
	assign wrappedHigh = frameStore[11:8]
		+ wrapOffset(latchBits[screenSizeHi:screenSizeLo], frameStore[12]);

	// Character cell layout, eight scanlines per byte column
	assign fullAddr = {wrappedHigh, frameStore[7:0], rowAddr[2:0]};

	// Smaller machines drop the top bit
	assign videoAddr = fullAddr[ramAddrWidth-1:0];

endmodule

`default_nettype wire

// File: verilog/memoryArbiter.sv
`timescale 1ns/1ps
`default_nettype none

module memoryArbiter
	import beebMemPkg::*;
#(
	parameter int ramAddrWidth = 15
) (
	input logic CLK_PROC,
	input logic rst,
	procBusIf.mem bus,
	input logic sheila,
	input logic romSelWrite,
	input logic [ramAddrWidth-1:0] videoAddr,
	input logic [dataWidth-1:0] romData,
	output logic [romAddrWidth-1:0] romAddr,
	output romSlot romSlotSel,
	output logic [dataWidth-1:0] readData,
	output logic [dataWidth-1:0] videoData
);

	logic [dataWidth-1:0] ram [2**ramAddrWidth];
	logic [3:0] romBank;
	logic [ramAddrWidth-1:0] procRamAddr;
	logic procHalf;
	logic procWrite;
	logic procRead;

	assign procHalf = bus.phi2;
	assign procWrite = procHalf & ~bus.rnw;
	assign procRead = procHalf & bus.rnw;
	assign procRamAddr = bus.addr[ramAddrWidth-1:0];

	assign romAddr = bus.addr[romAddrWidth-1:0];

	// OS ROM sits at C000-FFFF around SHEILA, BASIC is bank 0 at 8000-BFFF
	always_comb begin
		if ((&bus.addr[15:14]) && !sheila) begin
			romSlotSel = romOs;
		end else if (bus.addr[15:14] == 2'b10 && romBank == 4'd0) begin
			romSlotSel = romBasic;
		end else begin
			romSlotSel = romNone;
		end
	end

	// Only the processor writes RAM
	always_ff @(posedge CLK_PROC) begin
		if (procWrite && !bus.addr[15]) begin
			ram[procRamAddr] <= bus.writeData;
		end
	end

	// Paged ROM select latch at FE30
	always_ff @(posedge CLK_PROC) begin
		if (rst) begin
			romBank <= '0;
		end else if (procWrite && romSelWrite) begin
			romBank <= bus.writeData[3:0];
		end
	end

	// Processor read path
	always_ff @(posedge CLK_PROC) begin
		if (rst) begin
			readData <= '0;
		end else if (procRead) begin
			if (!bus.addr[15]) begin
				readData <= ram[procRamAddr];
			end else if (romSlotSel != romNone) begin
				readData <= romData;
			end else begin
				// Unmapped ROM space and SHEILA float high
				readData <= '1;
			end
		end
	end

	// CRTC fetch during the low half of phi2
	always_ff @(posedge CLK_PROC) begin
		if (rst) begin
			videoData <= '0;
		end else if (!procHalf) begin
			videoData <= ram[videoAddr];
		end
	end

	// I/O page must never fall through to the OS ROM
	assertNoOsInSheila: assert property (
		@(posedge CLK_PROC) disable iff (rst)
		romSlotSel == romOs |-> bus.addr[15:8] != 8'hFE
	) else $error("memoryArbiter: OS ROM selected inside SHEILA at %h", bus.addr);

endmodule

`default_nettype wire

// File: verilog/beebMemory.sv
`timescale 1ns/1ps
`default_nettype none

module beebMemory
	import beebMemPkg::*;
#(
	parameter int ramAddrWidth = 15
) (
	input logic CLK_PROC,
	input logic rst,
	input logic phi2,
	input logic rnw,
	input logic [addrWidth-1:0] addr,
	input logic [dataWidth-1:0] writeData,
	input logic [frameWidth-1:0] frameStore,
	input logic [rowWidth-1:0] rowAddr,
	input logic latchWrite,
	input logic [2:0] latchIndex,
	input logic latchData,
	input logic [dataWidth-1:0] romData,
	output logic [dataWidth-1:0] readData,
	output logic [dataWidth-1:0] videoData,
	output logic [romAddrWidth-1:0] romAddr,
	output romSlot romSlotSel,
	output devSel sel,
	output logic [7:0] latchBits
);

	logic sheila;
	logic [ramAddrWidth-1:0] videoAddr;

	procBusIf bus ();

	assign bus.phi2 = phi2;
	assign bus.rnw = rnw;
	assign bus.addr = addr;
	assign bus.writeData = writeData;

	sheilaDecode decode_i (
		.bus(bus.decode),
		.sheila(sheila),
		.sel(sel)
	);

	systemLatch latch_i (
		.CLK_PROC(CLK_PROC),
		.rst(rst),
		.latchWrite(latchWrite),
		.latchIndex(latchIndex),
		.latchData(latchData),
		.latchBits(latchBits)
	);

	screenAddrMap #(
		.ramAddrWidth(ramAddrWidth)
	) screen_i (
		.frameStore(frameStore),
		.rowAddr(rowAddr),
		.latchBits(latchBits),
		.videoAddr(videoAddr)
	);

	memoryArbiter #(
		.ramAddrWidth(ramAddrWidth)
	) arbiter_i (
		.CLK_PROC(CLK_PROC),
		.rst(rst),
		.bus(bus.mem),
		.sheila(sheila),
		.romSelWrite(sel[selRomSel]),
		.videoAddr(videoAddr),
		.romData(romData),
		.romAddr(romAddr),
		.romSlotSel(romSlotSel),
		.readData(readData),
		.videoData(videoData)
	);

endmodule

`default_nettype wire

// File: tests/beebMemoryTb.sv
`timescale 1ns/1ps
`default_nettype none

module beebMemoryTb
	import beebMemPkg::*;
();

	localparam int clockPeriod = 10;
	// Reset, then tests 1 to 5, plus drain cycles
	localparam int testCycles = 9 + 4 + 201 + 130 + 36 + 146;
	localparam int timeoutNs = (testCycles + 100) * clockPeriod;

	logic CLK_PROC = 1'b0;
	logic rst;
	logic phi2;
	logic rnw;
	logic latchWrite;
	logic latchData;
	logic [15:0] addr;
	logic [7:0] writeData;
	logic [7:0] romData;
	logic [7:0] readData;
	logic [7:0] videoData;
	logic [7:0] latchBits;
	logic [13:0] frameStore;
	logic [13:0] romAddr;
	logic [4:0] rowAddr;
	logic [2:0] latchIndex;
	romSlot romSlotSel;
	devSel sel;

	logic [31:0] lfsrState = 32'h8675_776b;
	logic [7:0] shadowRam [32768];
	logic [3:0] romBankRef = 4'd0;
	logic [7:0] latchRef = 8'd0;
	logic [7:0] readQ [$];
	logic [7:0] videoQ [$];
	logic [7:0] readExp;
	logic [7:0] videoExp;
	logic readWait = 1'b0;
	logic videoWait = 1'b0;
	int checkCount = 0;
	int errorCount = 0;
	int testErrors = 0;

	beebMemory #(.ramAddrWidth(15)) dut_i (.*);

	always #(clockPeriod / 2) CLK_PROC = ~CLK_PROC;

	// ROM model answering on the slot the DUT picks
	always_comb begin
		case (romSlotSel)
			romOs: romData = romAddr[7:0] ^ 8'hA5;
			romBasic: romData = romAddr[7:0] ^ 8'h3C;
			default: romData = 8'h00;
		endcase
	end

	function automatic logic [31:0] randBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			value = {value[30:0], lfsrState[0]};
			lfsrState = (lfsrState >> 1) ^ (lfsrState[0] ? 32'h8020_0003 : 32'h0);
		end
		return value;
	endfunction

	function automatic devSel refSelect(input logic [15:0] a, input logic readNotWrite);
		devSel s;
		s = '0;
		if (a[15:8] == 8'hFE) begin
			case (a[7:0]) inside
				[8'h00:8'h07]: s[selCrtc] = 1'b1;
				[8'h08:8'h0F]: s[selAcia] = 1'b1;
				[8'h20:8'h2F]: s[selVidProc] = !readNotWrite;
				[8'h30:8'h3F]: s[selRomSel] = !readNotWrite;
				[8'h40:8'h5F]: s[selVia] = 1'b1;
				[8'h60:8'h7F]: s[selUserVia] = 1'b1;
				[8'h80:8'h9F]: s[selFdc] = 1'b1;
				[8'hC0:8'hDF]: s[selAdc] = 1'b1;
				[8'hE0:8'hFF]: s[selTube] = 1'b1;
				default: s = '0;
			endcase
		end
		return s;
	endfunction

	function automatic romSlot refSlot(input logic [15:0] a);
		if (a[15:14] == 2'b11 && a[15:8] != 8'hFE) begin
			return romOs;
		end else if (a[15:14] == 2'b10 && romBankRef == 4'd0) begin
			return romBasic;
		end
		return romNone;
	endfunction

	function automatic logic [7:0] refRead(input logic [15:0] a);
		if (!a[15]) begin
			return shadowRam[a[14:0]];
		end
		case (refSlot(a))
			romOs: return a[7:0] ^ 8'hA5;
			romBasic: return a[7:0] ^ 8'h3C;
			default: return 8'hFF;
		endcase
	endfunction

	function automatic logic [14:0] refScreenAddr(input logic [13:0] frame,
			input logic [4:0] row, input logic [1:0] size);
		logic [3:0] offset;
		logic [3:0] high;
		offset = 4'd0;
		if (frame[12]) begin
			case (size)
				2'd0: offset = 4'd8;
				2'd1: offset = 4'd12;
				2'd2: offset = 4'd6;
				default: offset = 4'd11;
			endcase
		end
		high = frame[11:8] + offset;
		return {high, frame[7:0], row[2:0]};
	endfunction

	task automatic checkByte(input string name, input logic [7:0] got, input logic [7:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("** Error: %s got %h expected %h at %0t", name, got, exp, $time);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkSel(input devSel got, input devSel exp);
		checkCount++;
		if (got !== exp) begin
			$display("** Error: sel got %h expected %h at %0t", got, exp, $time);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkSlot(input romSlot got, input romSlot exp);
		checkCount++;
		if (got !== exp) begin
			$display("** Error: romSlotSel got %h expected %h at %0t", got, exp, $time);
			errorCount++;
			testErrors++;
		end
	endtask

	task automatic checkRomAddr(input logic [romAddrWidth-1:0] got,
			input logic [romAddrWidth-1:0] exp);
		checkCount++;
		if (got !== exp) begin
			$display("** Error: romAddr got %h expected %h at %0t", got, exp, $time);
			errorCount++;
			testErrors++;
		end
	endtask

	// Registered outputs are compared one cycle after the request
	always @(negedge CLK_PROC) begin
		if (readWait) begin
			checkByte("readData", readData, readExp);
			readWait = 1'b0;
		end
		if (readQ.size() > 0) begin
			readExp = readQ.pop_front();
			readWait = 1'b1;
		end
		if (videoWait) begin
			checkByte("videoData", videoData, videoExp);
			videoWait = 1'b0;
		end
		if (videoQ.size() > 0) begin
			videoExp = videoQ.pop_front();
			videoWait = 1'b1;
		end
	end

	task automatic idleCycle();
		@(posedge CLK_PROC);
		phi2 <= 1'b1;
		rnw <= 1'b1;
		addr <= 16'hFE10;
		latchWrite <= 1'b0;
	endtask

	task automatic procRead(input logic [15:0] a);
		@(posedge CLK_PROC);
		phi2 <= 1'b1;
		rnw <= 1'b1;
		addr <= a;
		readQ.push_back(refRead(a));
		@(negedge CLK_PROC);
		checkSlot(romSlotSel, refSlot(a));
		checkRomAddr(romAddr, a[13:0]);
		checkSel(sel, refSelect(a, 1'b1));
	endtask

	task automatic procWrite(input logic [15:0] a, input logic [7:0] d);
		@(posedge CLK_PROC);
		phi2 <= 1'b1;
		rnw <= 1'b0;
		addr <= a;
		writeData <= d;
		if (!a[15]) begin
			shadowRam[a[14:0]] = d;
		end else if (a[15:4] == 12'hFE3) begin
			romBankRef = d[3:0];
		end
	endtask

	task automatic videoFetch(input logic [13:0] frame, input logic [4:0] row);
		@(posedge CLK_PROC);
		phi2 <= 1'b0;
		frameStore <= frame;
		rowAddr <= row;
		videoQ.push_back(shadowRam[refScreenAddr(frame, row, latchRef[5:4])]);
	endtask

	task automatic latchSet(input logic [2:0] index, input logic value);
		@(posedge CLK_PROC);
		latchWrite <= 1'b1;
		latchIndex <= index;
		latchData <= value;
		latchRef[index] = value;
	endtask

	task automatic endTest(input int number, input string name);
		while (readQ.size() != 0 || readWait || videoQ.size() != 0 || videoWait) begin
			@(negedge CLK_PROC);
		end
		if (testErrors == 0) begin
			$display("test %0d %s: ok", number, name);
		end else begin
			$display("test %0d %s: %0d errors", number, name, testErrors);
		end
		testErrors = 0;
	endtask

	initial begin
		#(timeoutNs);
		$display("watchdog: run did not finish within %0d ns", timeoutNs);
		$display("tests failed");
		$finish;
	end

	initial begin
		logic [15:0] a;
		logic [14:0] ramAddrs [64];
		logic [13:0] frame;
		logic [14:0] screenAddr;
		logic rw;
		rst <= 1'b1;
		phi2 <= 1'b1;
		rnw <= 1'b1;
		addr <= 16'hFE10;
		writeData <= 8'h00;
		frameStore <= '0;
		rowAddr <= '0;
		latchWrite <= 1'b0;
		latchIndex <= '0;
		latchData <= 1'b0;
		repeat (8) @(posedge CLK_PROC);
		rst <= 1'b0;

		@(negedge CLK_PROC);
		checkByte("readData", readData, 8'h00);
		checkByte("videoData", videoData, 8'h00);
		checkByte("latchBits", latchBits, 8'h00);
		// BASIC answering means the bank register came out of reset as zero
		procRead({2'b10, 14'(randBits(14))});
		idleCycle();
		endTest(1, "reset");

		// Video half, so FE30 writes cannot disturb the bank register
		for (int i = 0; i < 200; i++) begin
			a = {8'hFE, 8'(randBits(8))};
			rw = 1'(randBits(1));
			@(posedge CLK_PROC);
			phi2 <= 1'b0;
			rnw <= rw;
			addr <= a;
			@(negedge CLK_PROC);
			checkSel(sel, refSelect(a, rw));
		end
		idleCycle();
		endTest(2, "device selects");

		for (int i = 0; i < 64; i++) begin
			ramAddrs[i] = 15'(randBits(15));
			procWrite({1'b0, ramAddrs[i]}, 8'(randBits(8)));
		end
		for (int i = 0; i < 64; i++) begin
			procRead({1'b0, ramAddrs[i]});
		end
		idleCycle();
		endTest(3, "RAM path");

		for (int i = 0; i < 8; i++) begin
			do begin
				a = {2'b11, 14'(randBits(14))};
			end while (a[15:8] == 8'hFE);
			procRead(a);
		end
		for (int i = 0; i < 8; i++) begin
			procRead({2'b10, 14'(randBits(14))});
		end
		procWrite({12'hFE3, 4'(randBits(4))}, {4'(randBits(4)), 4'(randBits(4)) | 4'h1});
		for (int i = 0; i < 8; i++) begin
			procRead({2'b10, 14'(randBits(14))});
		end
		for (int i = 0; i < 8; i++) begin
			procRead({8'hFE, 8'(randBits(8))});
		end
		idleCycle();
		endTest(4, "ROM slots");

		for (int size = 0; size < 4; size++) begin
			latchSet(3'd4, size[0]);
			latchSet(3'd5, size[1]);
			idleCycle();
			@(negedge CLK_PROC);
			checkByte("latchBits", latchBits, latchRef);
			// Plant a known byte where the fetch should land, then fetch it
			for (int i = 0; i < 16; i++) begin
				frame = 14'(randBits(14));
				frame[12] = i[0];
				a = 16'(randBits(5));
				screenAddr = refScreenAddr(frame, a[4:0], latchRef[5:4]);
				procWrite({1'b0, screenAddr}, 8'(randBits(8)));
				videoFetch(frame, a[4:0]);
			end
			idleCycle();
		end
		endTest(5, "screen wrap and video path");

		$display("checks: %0d, errors: %0d", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("all tests passed");
		end else begin
			$display("tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: beebMemory.f
verilog/beebMemPkg.sv
verilog/procBusIf.sv
verilog/sheilaDecode.sv
verilog/systemLatch.sv
verilog/screenAddrMap.sv
verilog/memoryArbiter.sv
verilog/beebMemory.sv
tests/beebMemoryTb.sv

// File: Makefile
VERILATOR ?= verilator
TOP ?= beebMemoryTb
FLAGS ?= --binary --timing --assert -j 0
FILELIST ?= beebMemory.f
BUILD_DIR ?= obj_dir
PASS_TEXT ?= all tests passed

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
